/* adc_capture_top.f */
rtl/adc_lane_pkg.sv
rtl/adc_frame_pkg.sv
rtl/lane_deserializer.sv
rtl/iq_frame_builder.sv
rtl/frame_emitter.sv
rtl/adc_capture_top.sv
test/tb_adc_capture_top.sv

/* Makefile */
# Verilator build and run for the converter capture path

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
TOP       := tb_adc_capture_top
FILELIST  := adc_capture_top.f

BIN       := obj_dir/$(TOP)
SOURCES   := $(wildcard rtl/*.sv test/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* test/tb_adc_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the four-lane capture path
module tb_adc_capture_top;

    localparam int rand_groups = 40;   // Back-to-back half, then gapped half
    localparam int wrap_groups = 260;  // Unsynced stretch that drives frame_seq past 255
    localparam int total_groups = rand_groups + wrap_groups;
    localparam int max_gap = 3;        // Idle cycles before a strobe, at most
    // Every word takes at most max_gap + 1 cycles, plus margin for reset and drain
    localparam int cycle_limit = rand_groups * 4 * (max_gap + 1) + wrap_groups * 4 + 100;
    localparam int data_msb = adc_frame_pkg::data_width - 1;
    localparam int info_lsb = adc_frame_pkg::data_width;
    localparam int word_msb = adc_lane_pkg::word_width - 1;

    // Expected frame pair as raw words
    typedef struct packed {
        adc_lane_pkg::lane_word_t [adc_frame_pkg::frame_samples-1:0] i_word;
        adc_lane_pkg::lane_word_t [adc_frame_pkg::frame_samples-1:0] q_word;
        logic                                                        sync;
        logic [adc_frame_pkg::seq_width-1:0]                         seq;
    } frame_ref_t;

    logic                                clk_0 = 1'b0;
    logic                                rst_n;
    logic                                sample_strobe;
    adc_lane_pkg::lane_words_t           lane_words;
    logic                                sync_pps;
    logic                                frame_valid;
    adc_frame_pkg::iq_frame_t            i_frame;
    adc_frame_pkg::iq_frame_t            q_frame;
    logic                                frame_sync;
    logic [adc_frame_pkg::seq_width-1:0] frame_seq;

    logic       sync_hold;          // Level held on sync_pps across groups
    logic [2:0] acc_hist;           // Fourth-word accepts, one bit per past edge
    frame_ref_t exp_f;              // Reference frame lined up with frame_valid
    frame_ref_t ref_q [$];
    int         frames_seen;
    int         cycles = 0;
    bit         wrapped = 1'b0;     // Reference counter went 255 -> 0 without sync
    int         latency_errs = 0;
    int         frame_errs = 0;
    int         sync_errs = 0;
    int         seq_errs = 0;
    int         other_errs = 0;

    adc_capture_top DUT (
        .clk_0         (clk_0),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .lane_words    (lane_words),
        .sync_pps      (sync_pps),
        .frame_valid   (frame_valid),
        .i_frame       (i_frame),
        .q_frame       (q_frame),
        .frame_sync    (frame_sync),
        .frame_seq     (frame_seq)
    );

    always #4 clk_0 = ~clk_0;  // 8 ns period

    // ----------------------------------------------------------------------
    // Reference model fed by the same strobes the DUT accepts
    // ----------------------------------------------------------------------
    adc_lane_pkg::lane_word_t m_words [adc_lane_pkg::lane_count][adc_lane_pkg::group_depth];
    int                       m_phase;
    logic                     m_pend;       // Sync edge waiting for its group
    logic                     m_sync_prev;
    logic [7:0]               ref_seq;
    int                       pushed;

    always @(posedge clk_0 or negedge rst_n)
    begin
        frame_ref_t f;
        logic       rise;
        logic       accept;
        int         idx;
        if (!rst_n)
        begin
            m_phase     = 0;
            m_pend      = 1'b0;
            m_sync_prev = 1'b0;
            ref_seq     = 8'hff;   // First frame then counts to 0
            pushed      = 0;
            ref_q.delete();
            acc_hist    <= '0;
            exp_f       <= '0;
            frames_seen <= 0;
        end
        else
        begin
            rise        = sync_pps && !m_sync_prev;
            m_sync_prev = sync_pps;
            accept      = sample_strobe && (m_phase == adc_lane_pkg::group_depth - 1);
            if (sample_strobe)
            begin
                for (int l = 0; l < adc_lane_pkg::lane_count; l++)
                    m_words[l][m_phase] = lane_words.word[l];
                m_phase = (m_phase + 1) % adc_lane_pkg::group_depth;
            end
            if (accept)
            begin
                f = '0;
                // Even lane gives samples 0..3, odd lane 4..7; lanes 0/1 are I
                for (int l = 0; l < adc_lane_pkg::lane_count; l++)
                begin
                    for (int t = 0; t < adc_lane_pkg::group_depth; t++)
                    begin
                        idx = (l % 2) * adc_lane_pkg::group_depth + t;
                        if (l < 2)
                            f.i_word[idx] = m_words[l][t];
                        else
                            f.q_word[idx] = m_words[l][t];
                    end
                end
                f.sync  = m_pend || rise;  // Edge on the closing strobe counts too
                m_pend  = 1'b0;
                ref_seq = f.sync ? 8'd0 : ref_seq + 8'd1;
                if (!f.sync && ref_seq == 8'd0 && pushed > 0)
                    wrapped = 1'b1;
                f.seq  = ref_seq;
                pushed = pushed + 1;
                ref_q.push_back(f);
            end
            else if (rise)
                m_pend = 1'b1;
            acc_hist <= {acc_hist[1:0], accept};
            // Frame due on the next edge, present its reference now
            if (acc_hist[1])
                exp_f <= ref_q.pop_front();
            if (frame_valid)
                frames_seen <= frames_seen + 1;
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk_0) !rst_n |-> !frame_valid)
    else
    begin
        latency_errs = latency_errs + 1;
        $display("error reset_quiet: expected 0 actual %0b", $sampled(frame_valid));
    end

    // Three stages after the accepting edge
    a_latency: assert property (@(posedge clk_0) disable iff (!rst_n)
        frame_valid == acc_hist[2])
    else
    begin
        latency_errs = latency_errs + 1;
        $display("error latency: expected %0b actual %0b",
                 $sampled(acc_hist[2]), $sampled(frame_valid));
    end

    a_single_pulse: assert property (@(posedge clk_0) disable iff (!rst_n)
        frame_valid |=> !frame_valid)
    else
    begin
        latency_errs = latency_errs + 1;
        $display("error single_pulse: expected 0 actual %0b", $sampled(frame_valid));
    end

    a_sync: assert property (@(posedge clk_0) disable iff (!rst_n)
        frame_valid |-> (frame_sync == exp_f.sync))
    else
    begin
        sync_errs = sync_errs + 1;
        $display("error sync: expected %0b actual %0b",
                 $sampled(exp_f.sync), $sampled(frame_sync));
    end

    a_seq: assert property (@(posedge clk_0) disable iff (!rst_n)
        frame_valid |-> (frame_seq == exp_f.seq))
    else
    begin
        seq_errs = seq_errs + 1;
        $display("error seq: expected %0d actual %0d", $sampled(exp_f.seq), $sampled(frame_seq));
    end

    // Data and info per sample, both frames
    for (genvar s = 0; s < adc_frame_pkg::frame_samples; s++)
    begin : g_sample
        a_i_data: assert property (@(posedge clk_0) disable iff (!rst_n)
            frame_valid |-> (i_frame.sample[s].data == exp_f.i_word[s][data_msb:0]))
        else
        begin
            frame_errs = frame_errs + 1;
            $display("error i_data[%0d]: expected %h actual %h", s,
                     $sampled(exp_f.i_word[s][data_msb:0]), $sampled(i_frame.sample[s].data));
        end
        a_i_info: assert property (@(posedge clk_0) disable iff (!rst_n)
            frame_valid |-> (i_frame.sample[s].info == exp_f.i_word[s][word_msb:info_lsb]))
        else
        begin
            frame_errs = frame_errs + 1;
            $display("error i_info[%0d]: expected %0d actual %0d", s,
                     $sampled(exp_f.i_word[s][word_msb:info_lsb]),
                     $sampled(i_frame.sample[s].info));
        end
        a_q_data: assert property (@(posedge clk_0) disable iff (!rst_n)
            frame_valid |-> (q_frame.sample[s].data == exp_f.q_word[s][data_msb:0]))
        else
        begin
            frame_errs = frame_errs + 1;
            $display("error q_data[%0d]: expected %h actual %h", s,
                     $sampled(exp_f.q_word[s][data_msb:0]), $sampled(q_frame.sample[s].data));
        end
        a_q_info: assert property (@(posedge clk_0) disable iff (!rst_n)
            frame_valid |-> (q_frame.sample[s].info == exp_f.q_word[s][word_msb:info_lsb]))
        else
        begin
            frame_errs = frame_errs + 1;
            $display("error q_info[%0d]: expected %0d actual %0d", s,
                     $sampled(exp_f.q_word[s][word_msb:info_lsb]),
                     $sampled(q_frame.sample[s].info));
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    // Word of group g that carries a one-cycle sync pulse or -1 for none
    function automatic int pulse_word(input int g);
        case (g)
            3:       return 0;
            8:       return 3;   // Pulse on the closing strobe
            14:      return 2;
            22:      return 1;
            27:      return 3;
            default: return -1;
        endcase
    endfunction

    task automatic send_group(input int g, input bit gapped, input int pulse_at);
        adc_lane_pkg::lane_words_t w;
        logic [31:0]               rnd;
        logic [1:0]                info;
        int                        gap;
        for (int t = 0; t < adc_lane_pkg::group_depth; t++)
        begin
            gap = gapped ? int'($urandom_range(max_gap, 0)) : 0;
            for (int l = 0; l < adc_lane_pkg::lane_count; l++)
            begin
                rnd  = $urandom();
                info = 2'(g + l + t);  // Walks every info value
                w.word[l] = {info, rnd[data_msb:0]};
            end
            repeat (gap)
            begin
                sample_strobe <= 1'b0;
                sync_pps      <= sync_hold;
                @(posedge clk_0);
            end
            sample_strobe <= 1'b1;
            lane_words    <= w;
            sync_pps      <= sync_hold || (t == pulse_at);
            @(posedge clk_0);
        end
    endtask

    // Run limit
    always @(posedge clk_0)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: frames did not all arrive within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        int total_errs;
        void'($urandom(76));
        rst_n         = 1'b0;
        sample_strobe = 1'b0;
        lane_words    = '0;
        sync_pps      = 1'b0;
        sync_hold     = 1'b0;
        repeat (5) @(posedge clk_0);
        rst_n <= 1'b1;
        for (int g = 0; g < rand_groups; g++)
        begin
            if (g == 31)
                sync_hold = 1'b1;  // Level over groups 31..35 tags only 31
            send_group(g, g >= rand_groups / 2, pulse_word(g));
            if (g == 35)
                sync_hold = 1'b0;
        end
        // Back-to-back groups without sync, long enough to wrap the counter
        for (int g = rand_groups; g < total_groups; g++)
            send_group(g, 1'b0, -1);
        sample_strobe <= 1'b0;
        sync_pps      <= 1'b0;
        while (frames_seen < total_groups)
            @(posedge clk_0);
        repeat (2) @(posedge clk_0);
        if (!wrapped)
        begin
            other_errs = other_errs + 1;
            $display("sequence counter never wrapped past 255 in the reference run");
        end
        if (ref_q.size() != 0)
        begin
            other_errs = other_errs + 1;
            $display("%0d expected frames never came out", ref_q.size());
        end
        total_errs = latency_errs + frame_errs + sync_errs + seq_errs + other_errs;
        $display("frames %0d, errors: latency %0d frame %0d sync %0d seq %0d other %0d",
                 frames_seen, latency_errs, frame_errs, sync_errs, seq_errs, other_errs);
        if (total_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/adc_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Four-lane converter capture path, strobe in and I/Q frames out
module adc_capture_top (
    input  wire                                  clk_0,
    input  wire                                  rst_n,
    input  wire                                  sample_strobe,
    input  wire adc_lane_pkg::lane_words_t       lane_words,
    input  wire                                  sync_pps,
    output logic                                 frame_valid,
    output adc_frame_pkg::iq_frame_t             i_frame,
    output adc_frame_pkg::iq_frame_t             q_frame,
    output logic                                 frame_sync,
    output logic [adc_frame_pkg::seq_width-1:0]  frame_seq
);

    // ----------------------------------------------------------------------
    // Internal links
    // ----------------------------------------------------------------------
    logic                         group_valid;   // Deserializer to builder
    adc_lane_pkg::lane_group_t    group;
    logic                         bundle_valid;  // Builder to emitter
    adc_frame_pkg::frame_bundle_t bundle;

    // ----------------------------------------------------------------------
    // Capture pipeline, three register stages
    // ----------------------------------------------------------------------
    lane_deserializer u_lane_deserializer (
        .clk_0         (clk_0),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .lane_words    (lane_words),
        .sync_pps      (sync_pps),
        .group_valid   (group_valid),
        .group         (group)
    );

    iq_frame_builder u_iq_frame_builder (
        .clk_0        (clk_0),
        .rst_n        (rst_n),
        .group_valid  (group_valid),
        .group        (group),
        .bundle_valid (bundle_valid),
        .bundle       (bundle)
    );

    frame_emitter u_frame_emitter (
        .clk_0        (clk_0),
        .rst_n        (rst_n),
        .bundle_valid (bundle_valid),
        .bundle       (bundle),
        .frame_valid  (frame_valid),
        .i_frame      (i_frame),
        .q_frame      (q_frame),
        .frame_sync   (frame_sync),
        .frame_seq    (frame_seq)
    );

endmodule

`default_nettype wire

/* rtl/frame_emitter.sv */
`timescale 1ns/1ps
`default_nettype none

// Output registers, frame strobe and sequence stamping
module frame_emitter (
    input  wire                                  clk_0,
    input  wire                                  rst_n,
    input  wire                                  bundle_valid,
    input  wire adc_frame_pkg::frame_bundle_t    bundle,
    output logic                                 frame_valid,  // One cycle per frame
    output adc_frame_pkg::iq_frame_t             i_frame,
    output adc_frame_pkg::iq_frame_t             q_frame,
    output logic                                 frame_sync,
    output logic [adc_frame_pkg::seq_width-1:0]  frame_seq
);

    logic [adc_frame_pkg::seq_width-1:0] seq_next;

    // ----------------------------------------------------------------------
    // Sequence numbering
    // ----------------------------------------------------------------------
    // Restart on sync, else count up and wrap
    assign seq_next = bundle.sync ? '0 : frame_seq + 1'b1;

    // ----------------------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_valid <= 1'b0;
            i_frame     <= '0;
            q_frame     <= '0;
            frame_sync  <= 1'b0;
            frame_seq   <= '1;  // Wrap value, first frame then reads 0
        end
        else
        begin
            frame_valid <= bundle_valid;
            if (bundle_valid)
            begin
                i_frame    <= bundle.i_frame;
                q_frame    <= bundle.q_frame;
                frame_sync <= bundle.sync;
                frame_seq  <= seq_next;
            end
            // Frame, flag and count hold between strobes
        end
    end

    // frame_seq holds between frames, so its past value is the previous frame's
    a_seq_step: assert property (@(posedge clk_0) disable iff (!rst_n)
        (frame_valid && !frame_sync) |-> (frame_seq == $past(frame_seq) + 1'b1));

endmodule

`default_nettype wire

/* rtl/iq_frame_builder.sv */
`timescale 1ns/1ps
`default_nettype none

// Reorders lane groups into I/Q frames, splits data from info
module iq_frame_builder (
    input  wire                            clk_0,
    input  wire                            rst_n,
    input  wire                            group_valid,
    input  wire adc_lane_pkg::lane_group_t group,
    output logic                           bundle_valid,  // One cycle per frame pair
    output adc_frame_pkg::frame_bundle_t   bundle
);

    adc_frame_pkg::iq_frame_t i_next;
    adc_frame_pkg::iq_frame_t q_next;

    // Info in the top bits, data in the low bits
    function automatic adc_frame_pkg::iq_sample_t split_word(
        input adc_lane_pkg::lane_word_t w
    );
        adc_frame_pkg::iq_sample_t s;
        s.data = w[adc_frame_pkg::data_width-1:0];
        s.info = w[adc_lane_pkg::word_width-1:adc_frame_pkg::data_width];
        return s;
    endfunction

    // ----------------------------------------------------------------------
    // Lane to sample mapping
    // ----------------------------------------------------------------------
    // Lanes 0/1 fill I, lanes 2/3 fill Q, second lane takes upper half
    always_comb
    begin
        for (int t = 0; t < adc_lane_pkg::group_depth; t++)
        begin
            i_next.sample[t] = split_word(group.word[0][t]);
            i_next.sample[t + adc_lane_pkg::group_depth] = split_word(group.word[1][t]);
            q_next.sample[t] = split_word(group.word[2][t]);
            q_next.sample[t + adc_lane_pkg::group_depth] = split_word(group.word[3][t]);
        end
    end

    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
            bundle_valid <= 1'b0;
        else
            bundle_valid <= group_valid;  // Single register stage
    end

    // Payload, loaded only with a group
    always_ff @(posedge clk_0)
    begin
        if (group_valid)
        begin
            bundle.i_frame <= i_next;
            bundle.q_frame <= q_next;
            bundle.sync    <= group.sync;  // Sync flag rides along
        end
    end

    // Builder adds exactly one cycle to the valid strobe
    a_bundle_latency: assert property (@(posedge clk_0) disable iff (!rst_n)
        bundle_valid == $past(group_valid));

endmodule

`default_nettype wire

/* rtl/lane_deserializer.sv */
`timescale 1ns/1ps
`default_nettype none

// Gathers four strobed words per lane into one lane group
module lane_deserializer (
    input  wire                            clk_0,
    input  wire                            rst_n,
    input  wire                            sample_strobe,  // Marks a valid lane_words
    input  wire adc_lane_pkg::lane_words_t lane_words,
    input  wire                            sync_pps,       // Level, edge detected here
    output logic                           group_valid,    // One cycle per group
    output adc_lane_pkg::lane_group_t      group
);

    adc_frame_pkg::gather_phase_t phase;  // Slot of the next accepted word

    // Words t0..t2 per lane, t3 goes straight into the group register
    adc_lane_pkg::lane_word_t [adc_lane_pkg::lane_count-1:0]
                              [adc_lane_pkg::group_depth-2:0] stage;

    logic                      sync_d;      // Registered copy of sync_pps
    logic                      sync_rise;
    logic                      sync_pend;   // Edge seen since last group closed
    logic                      last_word;   // Strobe lands in slot t3
    adc_lane_pkg::lane_group_t group_next;

    assign sync_rise = sync_pps & ~sync_d;
    assign last_word = sample_strobe && (phase == adc_frame_pkg::PH_T3);

    // ----------------------------------------------------------------------
    // Group assembly
    // ----------------------------------------------------------------------
    always_comb
    begin
        group_next.sync = sync_pend | sync_rise;  // Edge on the closing edge counts
        for (int l = 0; l < adc_lane_pkg::lane_count; l++)
        begin
            for (int t = 0; t < adc_lane_pkg::group_depth - 1; t++)
            begin
                group_next.word[l][t] = stage[l][t];
            end
            group_next.word[l][adc_lane_pkg::group_depth-1] = lane_words.word[l];
        end
    end

    // ----------------------------------------------------------------------
    // Phase, valid strobe and sync tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase       <= adc_frame_pkg::PH_T0;
            group_valid <= 1'b0;
            sync_d      <= 1'b0;
            sync_pend   <= 1'b0;
        end
        else
        begin
            sync_d      <= sync_pps;
            group_valid <= last_word;  // Valid in the cycle after t3
            if (sample_strobe)
            begin
                // Wraps T3 back to T0, no strobe means no advance
                phase <= adc_frame_pkg::gather_phase_t'(phase + 1'b1);
            end
            // Pending edge is handed to the group, then dropped
            if (last_word)
                sync_pend <= 1'b0;
            else if (sync_rise)
                sync_pend <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge clk_0)
    begin
        if (sample_strobe)
        begin
            for (int l = 0; l < adc_lane_pkg::lane_count; l++)
            begin
                for (int t = 0; t < adc_lane_pkg::group_depth - 1; t++)
                begin
                    if (phase == adc_frame_pkg::gather_phase_t'(t))
                        stage[l][t] <= lane_words.word[l];  // Slot tk per lane
                end
            end
        end
        if (last_word)
            group <= group_next;  // Held until next group closes
    end

    // A group needs four strobes, so two valid cycles in a row mean a broken phase
    a_group_single: assert property (@(posedge clk_0) disable iff (!rst_n)
        group_valid |=> !group_valid);

endmodule

`default_nettype wire

/* rtl/adc_frame_pkg.sv */
`default_nettype none

// I/Q frame side of the capture path
package adc_frame_pkg;

    // ----------------------------------------------------------------------
    // Sample and frame sizes
    // ----------------------------------------------------------------------
    localparam int data_width    = 12;  // Converter data bits
    localparam int info_width    = 2;   // Per-sample info bits
    localparam int frame_samples = 8;   // Samples per I or Q frame
    localparam int seq_width     = 8;   // Frame sequence counter

    typedef struct packed {
        logic [info_width-1:0] info;  // Top bits of the raw word
        logic [data_width-1:0] data;  // Low bits of the raw word
    } iq_sample_t;

    typedef struct packed {
        iq_sample_t [frame_samples-1:0] sample;  // Sample 0 is oldest of lane A
    } iq_frame_t;

    typedef struct packed {
        iq_frame_t i_frame;
        iq_frame_t q_frame;
        logic      sync;     // Frame follows a sync edge
    } frame_bundle_t;

    // Position of the next word inside a lane group
    typedef enum logic [1:0] {
        PH_T0,
        PH_T1,
        PH_T2,
        PH_T3
    } gather_phase_t;

endpackage

`default_nettype wire

/* rtl/adc_lane_pkg.sv */
`default_nettype none

// Raw converter side of the capture path
package adc_lane_pkg;

    // ----------------------------------------------------------------------
    // Lane geometry
    // ----------------------------------------------------------------------
    localparam int lane_count  = 4;   // Converter lanes
    localparam int word_width  = 14;  // Raw word, info on top of data
    localparam int group_depth = 4;   // Words t0..t3 gathered per lane

    // One raw word as it leaves a lane
    typedef logic [word_width-1:0] lane_word_t;

    // One word per lane, presented together on each sample strobe
    typedef struct packed {
        lane_word_t [lane_count-1:0] word;  // Indexed by lane
    } lane_words_t;

    // A completed lane group, word[lane][t]
    typedef struct packed {
        logic                                          sync;  // Sync edge seen
        lane_word_t [lane_count-1:0][group_depth-1:0] word;
    } lane_group_t;

endpackage

`default_nettype wire
